// File: rtl/flash_pkg.sv
`default_nettype none

package flash_pkg;

    localparam int WORD_W       = 32;
    localparam int HALF_W       = 16;
    localparam int WORD_ADDR_W  = 21;
    localparam int FLASH_ADDR_W = WORD_ADDR_W + 1; // extra bit picks the half.

    typedef logic [WORD_W-1:0]       word_t;
    typedef logic [HALF_W-1:0]       half_t;
    typedef logic [WORD_ADDR_W-1:0]  word_addr_t;
    typedef logic [FLASH_ADDR_W-1:0] flash_addr_t;

    // puts the flash back into read-array mode.
    localparam half_t FLASH_CMD_READ_ARRAY = 16'h00FF;

    // access time of the part is about 75 ns, so 4 cycles of a 25 MHz clock is safe.
    localparam int DEFAULT_WAIT_CYCLES = 4;

endpackage

`default_nettype wire

// File: rtl/bus_if.sv
`default_nettype none

interface bus_if
    import flash_pkg::*;
();

    logic       read;    // level, held until done.
    word_addr_t address;
    word_t      data_rd;
    logic       done;    // one-cycle pulse.

    modport master (
        output read,
        output address,
        input  data_rd,
        input  done
    );

    modport slave (
        input  read,
        input  address,
        output data_rd,
        output done
    );

endinterface

`default_nettype wire

// File: rtl/bus_arbiter.sv
`default_nettype none

module bus_arbiter (
    input  logic  clk,
    input  logic  rst,
    bus_if.slave  port0,
    bus_if.slave  port1,
    bus_if.master ctrl
);

    typedef enum logic {
        st_idle,
        st_owned
    } state_t;

    state_t state;
    logic   owner;        // 0 is port0, 1 is port1.
    logic   last_served;
    logic   any_request;
    logic   grant;
    logic   owned;

    assign any_request = port0.read || port1.read;

    // round-robin pick, only looked at in idle.
    always_comb begin
        if (port0.read && port1.read) begin
            grant = ~last_served;
        end else begin
            grant = port1.read;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= st_idle;
            owner       <= 1'b0;
            last_served <= 1'b0; // so port1 wins the first contest.
        end else begin
            case (state)
                st_idle: begin
                    if (any_request) begin
                        owner       <= grant;
                        last_served <= grant;
                        state       <= st_owned;
                    end
                end

                st_owned: begin
                    if (ctrl.done) begin
                        state <= st_idle;
                    end
                end

                default: state <= st_idle;
            endcase
        end
    end

    assign owned = (state == st_owned);

    // forward the owner's request.
    assign ctrl.read    = owned && (owner ? port1.read : port0.read);
    assign ctrl.address = owner ? port1.address : port0.address;

    // data goes to both; only the owner's done qualifies it.
    assign port0.data_rd = ctrl.data_rd;
    assign port1.data_rd = ctrl.data_rd;
    assign port0.done    = owned && !owner && ctrl.done;
    assign port1.done    = owned && owner && ctrl.done;

endmodule

`default_nettype wire

// File: rtl/flash_controller.sv
`default_nettype none

module flash_controller
    import flash_pkg::*;
#(
    parameter int WAIT_CYCLES = DEFAULT_WAIT_CYCLES
) (
    input  logic        clk,
    input  logic        rst,
    bus_if.slave        bus,
    output logic        flash_ce_n,
    output logic        flash_oe_n,
    output logic        flash_we_n,
    output flash_addr_t flash_address,
    output half_t       flash_dq_out,
    output logic        flash_dq_oe,
    input  half_t       flash_dq_in
);

    localparam int CNT_W = $clog2(WAIT_CYCLES);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(WAIT_CYCLES - 1);

    typedef enum logic [2:0] {
        st_reset,
        st_cmd,
        st_idle,
        st_low,
        st_high
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] wait_cnt;
    logic             last_wait;
    logic             done_q;
    word_t            data_q;

    assign last_wait = (wait_cnt == LAST_CNT);

    // the only value ever written to the flash.
    assign flash_dq_out = FLASH_CMD_READ_ARRAY;

    assign bus.data_rd = data_q;
    assign bus.done    = done_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= st_reset;
            wait_cnt      <= '0;
            flash_ce_n    <= 1'b1;
            flash_oe_n    <= 1'b1;
            flash_we_n    <= 1'b1;
            flash_dq_oe   <= 1'b0;
            flash_address <= '0;
            done_q        <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                // write read-array at address 0.
                st_reset: begin
                    flash_ce_n    <= 1'b0;
                    flash_we_n    <= 1'b0;
                    flash_dq_oe   <= 1'b1;
                    flash_address <= '0;
                    wait_cnt      <= '0;
                    state         <= st_cmd;
                end

                st_cmd: begin
                    if (last_wait) begin
                        flash_ce_n  <= 1'b1;
                        flash_we_n  <= 1'b1;
                        flash_dq_oe <= 1'b0;
                        state       <= st_idle;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end

                st_idle: begin
                    // read is still high in the done cycle; do not take it twice.
                    if (bus.read && !done_q) begin
                        flash_ce_n    <= 1'b0;
                        flash_oe_n    <= 1'b0;
                        flash_address <= {bus.address, 1'b0};
                        wait_cnt      <= '0;
                        state         <= st_low;
                    end
                end

                st_low: begin
                    if (last_wait) begin
                        flash_address <= {bus.address, 1'b1};
                        wait_cnt      <= '0;
                        state         <= st_high;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end

                st_high: begin
                    if (last_wait) begin
                        flash_ce_n <= 1'b1;
                        flash_oe_n <= 1'b1;
                        done_q     <= 1'b1;
                        state      <= st_idle;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end

                default: state <= st_reset;
            endcase
        end
    end

    // sample each half at the end of its wait.
    always_ff @(posedge clk) begin
        if (last_wait && state == st_low) begin
            data_q[15:0] <= flash_dq_in;
        end
        if (last_wait && state == st_high) begin
            data_q[31:16] <= flash_dq_in;
        end
    end

endmodule

`default_nettype wire

// File: rtl/flash_subsystem.sv
`default_nettype none

module flash_subsystem
    import flash_pkg::*;
#(
    parameter int WAIT_CYCLES = DEFAULT_WAIT_CYCLES
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_read,
    input  word_addr_t  fetch_address,
    output word_t       fetch_data,
    output logic        fetch_done,
    input  logic        mem_read,
    input  word_addr_t  mem_address,
    output word_t       mem_data,
    output logic        mem_done,
    output logic        flash_ce_n,
    output logic        flash_oe_n,
    output logic        flash_we_n,
    output flash_addr_t flash_address,
    output half_t       flash_dq_out,
    output logic        flash_dq_oe,
    input  half_t       flash_dq_in
);

    bus_if fetch_bus ();
    bus_if mem_bus ();
    bus_if ctrl_bus ();

    assign fetch_bus.read    = fetch_read;
    assign fetch_bus.address = fetch_address;
    assign fetch_data        = fetch_bus.data_rd;
    assign fetch_done        = fetch_bus.done;

    assign mem_bus.read      = mem_read;
    assign mem_bus.address   = mem_address;
    assign mem_data          = mem_bus.data_rd;
    assign mem_done          = mem_bus.done;

    bus_arbiter u_arbiter (
        .clk   (clk),
        .rst   (rst),
        .port0 (fetch_bus.slave),
        .port1 (mem_bus.slave),
        .ctrl  (ctrl_bus.master)
    );

    flash_controller #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_controller (
        .clk           (clk),
        .rst           (rst),
        .bus           (ctrl_bus.slave),
        .flash_ce_n    (flash_ce_n),
        .flash_oe_n    (flash_oe_n),
        .flash_we_n    (flash_we_n),
        .flash_address (flash_address),
        .flash_dq_out  (flash_dq_out),
        .flash_dq_oe   (flash_dq_oe),
        .flash_dq_in   (flash_dq_in)
    );

endmodule

`default_nettype wire

// File: tb/flash_model.sv
`default_nettype none

module flash_model
    import flash_pkg::*;
(
    input  logic        clk,
    input  logic        flash_ce_n,
    input  logic        flash_oe_n,
    input  logic        flash_we_n,
    input  flash_addr_t flash_address,
    input  half_t       flash_dq_out,
    input  logic        flash_dq_oe,
    output half_t       flash_dq_in
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam half_t READ_ARRAY   = 16'h00FF;
    localparam half_t STATUS_READY = 16'h0080; // status register with the ready bit set.

    logic array_mode = 1'b0;

    // array content is 3a + 0x1234 at halfword address a.
    function automatic half_t array_half(input flash_addr_t a);
        logic [31:0] wide;
        wide = {10'd0, a} * 32'd3 + 32'h1234;
        return wide[15:0];
    endfunction

    // the part takes the command while we_n is low.
    always @(posedge clk) begin
        if (!flash_ce_n && !flash_we_n && flash_dq_oe && flash_dq_out == READ_ARRAY) begin
            array_mode <= 1'b1;
        end
    end

    always_comb begin
        if (flash_ce_n || flash_oe_n) begin
            flash_dq_in = 16'hFFFF; // pulled up when nobody drives.
        end else if (!array_mode) begin
            flash_dq_in = STATUS_READY;
        end else begin
            flash_dq_in = array_half(flash_address);
        end
    end

endmodule

`default_nettype wire

// File: tb/flash_chk.sv
`default_nettype none

module flash_chk (
    input logic clk,
    input logic rst,
    input logic flash_oe_n,
    input logic flash_we_n,
    input logic flash_dq_oe,
    input logic fetch_done,
    input logic mem_done
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    no_read_during_write: assert property (
        @(posedge clk) disable iff (rst) flash_we_n || flash_oe_n
    ) else begin
        $error("we_n and oe_n are low together");
        fail_count++;
    end

    // data is only driven toward the flash for a write.
    dq_driven_only_in_write: assert property (
        @(posedge clk) disable iff (rst) flash_dq_oe |-> !flash_we_n
    ) else begin
        $error("dq_oe is high while we_n is high");
        fail_count++;
    end

    fetch_done_pulse: assert property (
        @(posedge clk) disable iff (rst) fetch_done |=> !fetch_done
    ) else begin
        $error("fetch_done is longer than one cycle");
        fail_count++;
    end

    mem_done_pulse: assert property (
        @(posedge clk) disable iff (rst) mem_done |=> !mem_done
    ) else begin
        $error("mem_done is longer than one cycle");
        fail_count++;
    end

    dones_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(fetch_done && mem_done)
    ) else begin
        $error("fetch_done and mem_done are high together");
        fail_count++;
    end

endmodule

`default_nettype wire

// File: tb/flash_tb.sv
`default_nettype none

module flash_tb
    import flash_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          WAIT_CYCLES    = 4;
    localparam int          RESET_CYCLES   = 8;
    localparam int          TIMEOUT_CYCLES = 200;
    localparam int          BURST_LEN      = 6;
    localparam string       TEST_FILE      = "tb/flash_tests.txt";
    localparam logic [31:0] LCG_SEED       = 32'd85;
    localparam logic [31:0] LCG_MUL        = 32'd1103515245;
    localparam logic [31:0] LCG_INC        = 32'd12345;

    logic        clk = 1'b0;
    logic        rst;
    logic        fetch_read;
    word_addr_t  fetch_address;
    word_t       fetch_data;
    logic        fetch_done;
    logic        mem_read;
    word_addr_t  mem_address;
    word_t       mem_data;
    logic        mem_done;
    logic        flash_ce_n;
    logic        flash_oe_n;
    logic        flash_we_n;
    flash_addr_t flash_address;
    half_t       flash_dq_out;
    logic        flash_dq_oe;
    half_t       flash_dq_in;

    logic [31:0] lcg_state;
    logic        last_served    = 1'b0; // 1 when the mem port was served last.
    logic        burst_port     = 1'b0;
    int          mismatch_count = 0;
    int          other_count    = 0;
    int          assert_count   = 0;

    always #20 clk = ~clk;

    flash_subsystem #(.WAIT_CYCLES (WAIT_CYCLES)) u_flash_subsystem (.*);

    flash_model u_flash_model (.*);

    bind flash_subsystem flash_chk u_flash_chk (
        .clk         (clk),
        .rst         (rst),
        .flash_oe_n  (flash_oe_n),
        .flash_we_n  (flash_we_n),
        .flash_dq_oe (flash_dq_oe),
        .fetch_done  (fetch_done),
        .mem_done    (mem_done)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * LCG_MUL + LCG_INC;
    endfunction

    function automatic word_addr_t random_address();
        lcg_state = lcg_next(lcg_state);
        return lcg_state[30:10];
    endfunction

    function automatic half_t flash_half(input flash_addr_t a);
        logic [31:0] wide;
        wide = {10'd0, a} * 32'd3 + 32'h1234;
        return wide[15:0];
    endfunction

    // low half at 2w, high half at 2w+1.
    function automatic word_t expected_word(input word_addr_t w);
        return {flash_half({w, 1'b1}), flash_half({w, 1'b0})};
    endfunction

    task automatic compare_value(input string name, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s %s expected %h actual %h", name, what, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_reset_phase();
        int cycles;
        int low_cycles;
        bit finished;
        cycles     = 0;
        low_cycles = 0;
        finished   = 1'b0;
        compare_value("reset", "ce_n oe_n we_n", 32'd7,
                      32'({flash_ce_n, flash_oe_n, flash_we_n}));
        compare_value("reset", "dq_oe", 32'd0, 32'(flash_dq_oe));
        compare_value("reset", "fetch_done mem_done", 32'd0, 32'({fetch_done, mem_done}));
        while (!finished && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (!flash_we_n) begin
                low_cycles++;
                compare_value("reset_cmd", "dq_out", 32'h0000_00FF, 32'(flash_dq_out));
                compare_value("reset_cmd", "address", 32'd0, 32'(flash_address));
            end else if (low_cycles > 0) begin
                finished = 1'b1;
            end
        end
        assert (finished) else begin
            $display("timeout: the read-array command phase never ended");
            other_count++;
        end
        compare_value("reset_cmd", "we_n low cycles", 32'(WAIT_CYCLES), 32'(low_cycles));
    endtask

    // one read on one port, started at the next falling edge.
    task automatic issue_read(input string name, input logic port, input word_addr_t addr,
                              input bit check_latency);
        int    cycles;
        bit    seen;
        logic  done_now;
        logic  other_done;
        word_t data_now;
        cycles = 0;
        seen   = 1'b0;
        @(negedge clk);
        if (port) begin
            mem_read    = 1'b1;
            mem_address = addr;
        end else begin
            fetch_read    = 1'b1;
            fetch_address = addr;
        end
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            done_now   = port ? mem_done : fetch_done;
            other_done = port ? fetch_done : mem_done;
            data_now   = port ? mem_data : fetch_data;
            compare_value(name, "other port done", 32'd0, 32'(other_done));
            if (done_now) begin
                seen = 1'b1;
                compare_value(name, "data", expected_word(addr), data_now);
                if (check_latency) begin
                    compare_value(name, "latency", 32'(2 * WAIT_CYCLES + 2), 32'(cycles));
                end
            end
        end
        assert (seen) else begin
            $display("timeout in test %s: done never came", name);
            other_count++;
        end
        last_served = port;
    endtask

    task automatic contested_read(input string name, input word_addr_t addr);
        word_addr_t fetch_addr;
        word_addr_t mem_addr;
        logic       exp_first;
        logic       first_port;
        logic       got_fetch;
        logic       got_mem;
        int         cycles;
        fetch_addr = addr;
        mem_addr   = addr + word_addr_t'(1);
        exp_first  = !last_served;
        first_port = 1'b0;
        got_fetch  = 1'b0;
        got_mem    = 1'b0;
        cycles     = 0;
        @(negedge clk);
        fetch_read    = 1'b1;
        fetch_address = fetch_addr;
        mem_read      = 1'b1;
        mem_address   = mem_addr;
        while (!(got_fetch && got_mem) && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (got_fetch) begin
                fetch_read = 1'b0; // served port steps back after its done edge.
            end
            if (got_mem) begin
                mem_read = 1'b0;
            end
            if (fetch_done) begin
                compare_value(name, "fetch data", expected_word(fetch_addr), fetch_data);
                first_port = got_mem;
                got_fetch  = 1'b1;
            end
            if (mem_done) begin
                compare_value(name, "mem data", expected_word(mem_addr), mem_data);
                first_port = !got_fetch;
                got_mem    = 1'b1;
            end
        end
        assert (got_fetch && got_mem) else begin
            $display("timeout in test %s: a contested read never finished", name);
            other_count++;
        end
        compare_value(name, "first port", 32'(exp_first), 32'(first_port));
        last_served = !first_port;
    endtask

    task automatic burst_reads(input string name, input word_addr_t first_addr);
        word_addr_t addr;
        addr = first_addr;
        for (int i = 0; i < BURST_LEN; i++) begin
            issue_read($sformatf("%s_%0d", name, i), burst_port, addr, 1'b0);
            addr = random_address();
        end
        burst_port = !burst_port;
    endtask

    task automatic release_ports();
        @(negedge clk);
        fetch_read = 1'b0;
        mem_read   = 1'b0;
    endtask

    task automatic dispatch_test(input string name, input string kind, input word_addr_t addr);
        if (kind == "fetch") begin
            issue_read(name, 1'b0, addr, 1'b1);
        end else if (kind == "mem") begin
            issue_read(name, 1'b1, addr, 1'b1);
        end else if (kind == "both") begin
            contested_read(name, addr);
        end else if (kind == "burst") begin
            burst_reads(name, addr);
        end else begin
            $display("test %s has an unknown kind %s", name, kind);
            other_count++;
        end
        release_ports();
    endtask

    task automatic read_test_file();
        int               fd;
        int               n;
        logic [8*80-1:0]  line;
        logic [8*24-1:0]  name_r;
        logic [8*24-1:0]  kind_r;
        logic [8*24-1:0]  addr_r;
        string            name;
        string            kind;
        string            addr_s;
        word_addr_t       addr;
        fd = $fopen(TEST_FILE, "r");
        assert (fd != 0) else begin
            $display("cannot open the test file %s", TEST_FILE);
            other_count++;
        end
        while (fd != 0 && !$feof(fd)) begin
            line   = '0;
            name_r = '0;
            kind_r = '0;
            addr_r = '0;
            n      = $fgets(line, fd);
            n      = $sscanf(line, "%s %s %s", name_r, kind_r, addr_r);
            name   = name_r;
            kind   = kind_r;
            addr_s = addr_r;
            if (n == 3 && name != "#") begin
                if (addr_s == "rand") begin
                    addr = random_address();
                end else begin
                    n = $sscanf(addr_r, "%h", addr);
                end
                dispatch_test(name, kind, addr);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    initial begin
        rst           = 1'b1;
        fetch_read    = 1'b0;
        fetch_address = '0;
        mem_read      = 1'b0;
        mem_address   = '0;
        lcg_state     = LCG_SEED;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
        end
        rst = 1'b0;
        check_reset_phase();
        read_test_file();
        assert_count = u_flash_subsystem.u_flash_chk.fail_count;
        $display("mismatches: %0d, other errors: %0d, assertion failures: %0d",
                 mismatch_count, other_count, assert_count);
        if (mismatch_count == 0 && other_count == 0 && assert_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/flash_tests.txt
# name kind address
# kind is fetch, mem, both or burst; address is a hex word address or rand
contest_reset both 000010
fetch_zero fetch 000000
mem_one mem 000001
contest_fetch_wins both 000100
fetch_top fetch 1fffff
contest_mem_wins both 1fffff
mem_rand mem rand
fetch_rand fetch rand
burst_fetch burst rand
burst_mem burst rand
contest_rand both rand
fetch_mid fetch 0abcde
mem_mid mem 123456

// File: compile.f
rtl/flash_pkg.sv
rtl/bus_if.sv
rtl/bus_arbiter.sv
rtl/flash_controller.sv
rtl/flash_subsystem.sv
tb/flash_model.sv
tb/flash_chk.sv
tb/flash_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= flash_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --assert --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
